/* source/decode_params.svh */
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

`define DATA_W       32
`define GREG_N       16
`define GREG_ID_W    4
`define PREG_N       4
`define PREG_ID_W    2
`define PREG_RESET   4'b0011  // p0 = p1 = 1, p2 = p3 = 0
`define OPCODE_W     6
`define IMM_FIELD_W  23
`define ALU_OP_W     4
`define EXT_SEL_W    2

// memory
`define OP_LD        6'h23
`define OP_ST        6'h24
// predicate logic and value tests
`define OP_RTOP      6'h26
`define OP_ANDP      6'h27
`define OP_ORP       6'h28
`define OP_XORP      6'h29
`define OP_NOTP      6'h2a
`define OP_ISNEG     6'h2b
`define OP_ISZERO    6'h2c
// immediate arithmetic
`define OP_LDI       6'h25
`define OP_ANDI      6'h11
`define OP_ORI       6'h12
`define OP_XORI      6'h13
`define OP_ADDI      6'h14
`define OP_SUBI      6'h15
`define OP_MULI      6'h16
`define OP_DIVI      6'h17
`define OP_MODI      6'h18
`define OP_SHLI      6'h19
`define OP_SHRI      6'h1a
// register arithmetic
`define OP_NEG       6'h05
`define OP_NOT       6'h06
`define OP_AND       6'h07
`define OP_OR        6'h08
`define OP_XOR       6'h09
`define OP_ADD       6'h0a
`define OP_SUB       6'h0b
`define OP_MUL       6'h0c
`define OP_DIV       6'h0d
`define OP_MOD       6'h0e
`define OP_SHL       6'h0f
`define OP_SHR       6'h10
// jumps
`define OP_JALI      6'h1b
`define OP_JALR      6'h1c
`define OP_JMPI      6'h1d
`define OP_JMPR      6'h1e

`define ALU_NOP      4'd0
`define ALU_ADD      4'd1
`define ALU_SUB      4'd2
`define ALU_MUL      4'd3
`define ALU_DIV      4'd4
`define ALU_MOD      4'd5
`define ALU_SHL      4'd6
`define ALU_SHR      4'd7
`define ALU_AND      4'd8
`define ALU_OR       4'd9
`define ALU_XOR      4'd10
`define ALU_NEG      4'd11
`define ALU_NOT      4'd12
`define ALU_LDI      4'd13
`define ALU_LINK     4'd14

// predicate unit ops share the alu_op lines
`define PRED_AND     4'd1
`define PRED_OR      4'd2
`define PRED_XOR     4'd3
`define PRED_NOT     4'd4
`define PRED_RTOP    4'd5
`define PRED_ISNEG   4'd6
`define PRED_ISZERO  4'd7

`define EXT_NONE     2'd0
`define EXT_15       2'd1
`define EXT_23       2'd2
`define EXT_19       2'd3

`endif

/* source/decode_pkg.sv */
`include "decode_params.svh"

package decode_pkg;

  // one instruction word, read either with register ids or with an immediate
  typedef union packed {
    struct packed {
      logic                                    guard_en;
      logic [`PREG_ID_W-1:0]                   guard_id;
      logic [`OPCODE_W-1:0]                    opcode;
      logic [`GREG_ID_W-1:0]                   rz;
      logic [`GREG_ID_W-1:0]                   ry;
      logic [`GREG_ID_W-1:0]                   rx;
      logic [`IMM_FIELD_W-3*`GREG_ID_W-1:0]    unused;
    } reg_view;
    struct packed {
      logic                                    guard_en;
      logic [`PREG_ID_W-1:0]                   guard_id;
      logic [`OPCODE_W-1:0]                    opcode;
      logic [`IMM_FIELD_W-1:0]                 imm_field;  // width depends on opcode
    } imm_view;
  } instr_t;

endpackage

/* source/instr_decoder.sv */
`timescale 1ns/1ns
`include "decode_params.svh"

module instr_decoder (
  input  decode_pkg::instr_t      inst,
  output logic [`GREG_ID_W-1:0]   x_id,
  output logic [`GREG_ID_W-1:0]   y_id,
  output logic [`GREG_ID_W-1:0]   z_id,
  output logic [`EXT_SEL_W-1:0]   ext_sel,
  output logic [`ALU_OP_W-1:0]    alu_op,
  output logic                    pf_imm,
  output logic                    src2_imm,
  output logic                    link,
  output logic                    mem_read,
  output logic                    mem_write,
  output logic                    wb_from_mem,
  output logic                    wb_pred,
  output logic                    wb_greg,
  output logic                    is_jump,
  output logic                    jump_imm,
  output logic                    has_ry,
  output logic                    has_rx
);

  logic [18:0] ctrl;
  logic        x_from_z;  // st and jmpr read rz on the x port

  // row layout: {has_rx has_ry}, {greg pred from_mem}, {mem_w mem_r}, {link src2_imm},
  // alu_op, {pf_imm jump_imm is_jump}, ext_sel, x_from_z
  always_comb
  begin
    case (inst.reg_view.opcode)
      `OP_LD:     ctrl = {2'b01, 3'b101, 2'b01, 2'b01, `ALU_ADD, 3'b100, `EXT_15, 1'b0};
      `OP_ST:     ctrl = {2'b01, 3'b000, 2'b10, 2'b01, `ALU_ADD, 3'b100, `EXT_15, 1'b1};
      `OP_ANDP:   ctrl = {2'b00, 3'b010, 2'b00, 2'b00, `PRED_AND, 3'b000, `EXT_NONE, 1'b0};
      `OP_ORP:    ctrl = {2'b00, 3'b010, 2'b00, 2'b00, `PRED_OR, 3'b000, `EXT_NONE, 1'b0};
      `OP_XORP:   ctrl = {2'b00, 3'b010, 2'b00, 2'b00, `PRED_XOR, 3'b000, `EXT_NONE, 1'b0};
      `OP_NOTP:   ctrl = {2'b00, 3'b010, 2'b00, 2'b00, `PRED_NOT, 3'b000, `EXT_NONE, 1'b0};
      `OP_RTOP:   ctrl = {2'b01, 3'b010, 2'b00, 2'b00, `PRED_RTOP, 3'b000, `EXT_NONE, 1'b0};
      `OP_ISNEG:  ctrl = {2'b01, 3'b010, 2'b00, 2'b00, `PRED_ISNEG, 3'b000, `EXT_NONE, 1'b0};
      `OP_ISZERO: ctrl = {2'b01, 3'b010, 2'b00, 2'b00, `PRED_ISZERO, 3'b000, `EXT_NONE, 1'b0};
      `OP_LDI:    ctrl = {2'b00, 3'b100, 2'b00, 2'b01, `ALU_LDI, 3'b100, `EXT_19, 1'b0};
      `OP_ADDI:   ctrl = {2'b01, 3'b100, 2'b00, 2'b01, `ALU_ADD, 3'b100, `EXT_15, 1'b0};
      `OP_SUBI:   ctrl = {2'b01, 3'b100, 2'b00, 2'b01, `ALU_SUB, 3'b100, `EXT_15, 1'b0};
      `OP_MULI:   ctrl = {2'b01, 3'b100, 2'b00, 2'b01, `ALU_MUL, 3'b100, `EXT_15, 1'b0};
      `OP_DIVI:   ctrl = {2'b01, 3'b100, 2'b00, 2'b01, `ALU_DIV, 3'b100, `EXT_15, 1'b0};
      `OP_MODI:   ctrl = {2'b01, 3'b100, 2'b00, 2'b01, `ALU_MOD, 3'b100, `EXT_15, 1'b0};
      `OP_SHLI:   ctrl = {2'b01, 3'b100, 2'b00, 2'b01, `ALU_SHL, 3'b100, `EXT_15, 1'b0};
      `OP_SHRI:   ctrl = {2'b01, 3'b100, 2'b00, 2'b01, `ALU_SHR, 3'b100, `EXT_15, 1'b0};
      `OP_ANDI:   ctrl = {2'b01, 3'b100, 2'b00, 2'b01, `ALU_AND, 3'b100, `EXT_15, 1'b0};
      `OP_ORI:    ctrl = {2'b01, 3'b100, 2'b00, 2'b01, `ALU_OR, 3'b100, `EXT_15, 1'b0};
      `OP_XORI:   ctrl = {2'b01, 3'b100, 2'b00, 2'b01, `ALU_XOR, 3'b100, `EXT_15, 1'b0};
      `OP_ADD:    ctrl = {2'b11, 3'b100, 2'b00, 2'b00, `ALU_ADD, 3'b100, `EXT_NONE, 1'b0};
      `OP_SUB:    ctrl = {2'b11, 3'b100, 2'b00, 2'b00, `ALU_SUB, 3'b100, `EXT_NONE, 1'b0};
      `OP_MUL:    ctrl = {2'b11, 3'b100, 2'b00, 2'b00, `ALU_MUL, 3'b100, `EXT_NONE, 1'b0};
      `OP_DIV:    ctrl = {2'b11, 3'b100, 2'b00, 2'b00, `ALU_DIV, 3'b100, `EXT_NONE, 1'b0};
      `OP_MOD:    ctrl = {2'b11, 3'b100, 2'b00, 2'b00, `ALU_MOD, 3'b100, `EXT_NONE, 1'b0};
      `OP_SHL:    ctrl = {2'b11, 3'b100, 2'b00, 2'b00, `ALU_SHL, 3'b100, `EXT_NONE, 1'b0};
      `OP_SHR:    ctrl = {2'b11, 3'b100, 2'b00, 2'b00, `ALU_SHR, 3'b100, `EXT_NONE, 1'b0};
      `OP_AND:    ctrl = {2'b11, 3'b100, 2'b00, 2'b00, `ALU_AND, 3'b100, `EXT_NONE, 1'b0};
      `OP_OR:     ctrl = {2'b11, 3'b100, 2'b00, 2'b00, `ALU_OR, 3'b100, `EXT_NONE, 1'b0};
      `OP_XOR:    ctrl = {2'b11, 3'b100, 2'b00, 2'b00, `ALU_XOR, 3'b100, `EXT_NONE, 1'b0};
      `OP_NEG:    ctrl = {2'b01, 3'b100, 2'b00, 2'b00, `ALU_NEG, 3'b100, `EXT_NONE, 1'b0};
      `OP_NOT:    ctrl = {2'b01, 3'b100, 2'b00, 2'b00, `ALU_NOT, 3'b100, `EXT_NONE, 1'b0};
      `OP_JMPI:   ctrl = {2'b00, 3'b000, 2'b00, 2'b00, `ALU_NOP, 3'b011, `EXT_23, 1'b0};
      `OP_JMPR:   ctrl = {2'b10, 3'b000, 2'b00, 2'b00, `ALU_NOP, 3'b001, `EXT_NONE, 1'b1};
      `OP_JALI:   ctrl = {2'b00, 3'b100, 2'b00, 2'b10, `ALU_LINK, 3'b111, `EXT_19, 1'b0};
      `OP_JALR:   ctrl = {2'b10, 3'b100, 2'b00, 2'b10, `ALU_LINK, 3'b101, `EXT_NONE, 1'b0};
      default:    ctrl = '0;  // nop, float ops, unknown
    endcase
  end

  assign {has_rx, has_ry, wb_greg, wb_pred, wb_from_mem, mem_write, mem_read,
          link, src2_imm, alu_op, pf_imm, jump_imm, is_jump, ext_sel, x_from_z} = ctrl;

  assign x_id = x_from_z ? inst.reg_view.rz : inst.reg_view.rx;
  assign y_id = inst.reg_view.ry;
  assign z_id = inst.reg_view.rz;

endmodule

/* source/pred_reg_file.sv */
`timescale 1ns/1ns
`include "decode_params.svh"

module pred_reg_file (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`PREG_ID_W-1:0]  x_id,
  input  logic [`PREG_ID_W-1:0]  y_id,
  input  logic                   wr,
  input  logic [`PREG_ID_W-1:0]  wr_id,
  input  logic                   wr_data,
  input  logic                   guard_en,
  input  logic [`PREG_ID_W-1:0]  guard_id,
  output logic                   px,
  output logic                   py,
  output logic                   pval
);

  logic [`PREG_N-1:0] pregs;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pregs <= `PREG_RESET;
    end
    else if (wr)
    begin
      pregs[wr_id] <= wr_data;  // seen on reads next cycle
    end
  end

  assign px = pregs[x_id];
  assign py = pregs[y_id];

  // unguarded instructions always execute
  assign pval = guard_en ? pregs[guard_id] : 1'b1;

endmodule

/* source/gen_reg_file.sv */
`timescale 1ns/1ns
`include "decode_params.svh"

module gen_reg_file (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`GREG_ID_W-1:0]  x_id,
  input  logic [`GREG_ID_W-1:0]  y_id,
  input  logic                   wr,
  input  logic [`GREG_ID_W-1:0]  wr_id,
  input  logic [`DATA_W-1:0]     wr_data,
  output logic [`DATA_W-1:0]     rx,
  output logic [`DATA_W-1:0]     ry
);

  logic [`DATA_W-1:0] gregs [`GREG_N];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < `GREG_N; i++)
      begin
        gregs[i] <= `DATA_W'(i);  // r_i starts at i
      end
    end
    else if (wr)
    begin
      gregs[wr_id] <= wr_data;
    end
  end

  // no write bypass
  assign rx = gregs[x_id];
  assign ry = gregs[y_id];

endmodule

/* source/imm_branch_unit.sv */
`timescale 1ns/1ns
`include "decode_params.svh"

module imm_branch_unit (
  input  decode_pkg::instr_t     inst,
  input  logic [`EXT_SEL_W-1:0]  ext_sel,
  input  logic [`DATA_W-1:0]     pc_next,
  output logic [`DATA_W-1:0]     imm,
  output logic [`DATA_W-1:0]     jmp_target
);

  logic [`IMM_FIELD_W-1:0] field;

  assign field = inst.imm_view.imm_field;

  always_comb
  begin
    case (ext_sel)
      `EXT_15:   imm = {{(`DATA_W-15){field[14]}}, field[14:0]};  // loads, stores, alu imm
      `EXT_23:   imm = {{(`DATA_W-23){field[22]}}, field[22:0]};  // jmpi
      `EXT_19:   imm = {{(`DATA_W-19){field[18]}}, field[18:0]};  // ldi, jali
      `EXT_NONE: imm = '0;
    endcase
  end

  // pc relative, wraps at 32 bits
  assign jmp_target = pc_next + imm;

endmodule

/* source/decode_stage.sv */
`timescale 1ns/1ns
`include "decode_params.svh"

module decode_stage (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`DATA_W-1:0]     pc_next,
  input  logic [`DATA_W-1:0]     inst,
  input  logic                   p_wr,
  input  logic [`PREG_ID_W-1:0]  p_wr_id,
  input  logic                   p_wr_data,
  input  logic                   r_wr,
  input  logic [`GREG_ID_W-1:0]  r_wr_id,
  input  logic [`DATA_W-1:0]     r_wr_data,
  output logic                   px,
  output logic                   py,
  output logic                   pval,
  output logic [`DATA_W-1:0]     rx,
  output logic [`DATA_W-1:0]     ry,
  output logic [`DATA_W-1:0]     imm,
  output logic [`DATA_W-1:0]     jmp_target,
  output logic [`GREG_ID_W-1:0]  z_id,
  output logic [`GREG_ID_W-1:0]  x_id,
  output logic [`GREG_ID_W-1:0]  y_id,
  output logic [`ALU_OP_W-1:0]   alu_op,
  output logic                   pf_imm,
  output logic                   src2_imm,
  output logic                   link,
  output logic                   mem_read,
  output logic                   mem_write,
  output logic                   wb_from_mem,
  output logic                   wb_pred,
  output logic                   wb_greg,
  output logic                   is_jump,
  output logic                   jump_imm,
  output logic                   has_ry,
  output logic                   has_rx
);

  decode_pkg::instr_t         instr;
  logic [`EXT_SEL_W-1:0]      ext_sel;

  assign instr = inst;

  instr_decoder u_instr_decoder (
    .inst        (instr),
    .x_id        (x_id),
    .y_id        (y_id),
    .z_id        (z_id),
    .ext_sel     (ext_sel),
    .alu_op      (alu_op),
    .pf_imm      (pf_imm),
    .src2_imm    (src2_imm),
    .link        (link),
    .mem_read    (mem_read),
    .mem_write   (mem_write),
    .wb_from_mem (wb_from_mem),
    .wb_pred     (wb_pred),
    .wb_greg     (wb_greg),
    .is_jump     (is_jump),
    .jump_imm    (jump_imm),
    .has_ry      (has_ry),
    .has_rx      (has_rx)
  );

  pred_reg_file u_pred_reg_file (
    .clk      (clk),
    .rst      (rst),
    .x_id     (x_id[`PREG_ID_W-1:0]),  // low bits name the predicate
    .y_id     (y_id[`PREG_ID_W-1:0]),
    .wr       (p_wr),
    .wr_id    (p_wr_id),
    .wr_data  (p_wr_data),
    .guard_en (instr.reg_view.guard_en),
    .guard_id (instr.reg_view.guard_id),
    .px       (px),
    .py       (py),
    .pval     (pval)
  );

  gen_reg_file u_gen_reg_file (
    .clk     (clk),
    .rst     (rst),
    .x_id    (x_id),
    .y_id    (y_id),
    .wr      (r_wr),
    .wr_id   (r_wr_id),
    .wr_data (r_wr_data),
    .rx      (rx),
    .ry      (ry)
  );

  imm_branch_unit u_imm_branch_unit (
    .inst       (instr),
    .ext_sel    (ext_sel),
    .pc_next    (pc_next),
    .imm        (imm),
    .jmp_target (jmp_target)
  );

endmodule

/* testbench/decode_checker.sv */
`timescale 1ns/1ns
`include "decode_params.svh"

module decode_checker (
  input logic                  clk,
  input logic                  rst,
  input logic [`DATA_W-1:0]    inst,
  input logic [`ALU_OP_W-1:0]  alu_op,
  input logic                  pf_imm,
  input logic                  src2_imm,
  input logic                  link,
  input logic                  mem_read,
  input logic                  mem_write,
  input logic                  wb_from_mem,
  input logic                  wb_pred,
  input logic                  wb_greg,
  input logic                  is_jump,
  input logic                  jump_imm,
  input logic                  has_ry,
  input logic                  has_rx
);

  decode_pkg::instr_t word;
  logic [15:0]        ctrl_all;
  int unsigned        fail_cnt = 0;

  assign word = inst;
  assign ctrl_all = {alu_op, pf_imm, src2_imm, link, mem_read, mem_write, wb_from_mem,
                     wb_pred, wb_greg, is_jump, jump_imm, has_ry, has_rx};

  mem_excl: assert property (@(posedge clk) disable iff (rst) !(mem_read && mem_write))
  else
  begin
    fail_cnt++;
    $error("mem_read and mem_write are high together");
  end

  nop_zero: assert property (@(posedge clk) disable iff (rst)
    (word.reg_view.opcode == '0) |-> (ctrl_all == '0))
  else
  begin
    fail_cnt++;
    $error("nop instruction drives a nonzero control output");
  end

  // a jump never touches memory
  jump_no_mem: assert property (@(posedge clk) disable iff (rst)
    is_jump |-> !(mem_read || mem_write))
  else
  begin
    fail_cnt++;
    $error("jump instruction drives a memory access");
  end

endmodule

bind decode_stage decode_checker u_decode_checker (.*);

/* testbench/tb_decode_stage.sv */
`timescale 1ns/1ns
`include "decode_params.svh"

module tb_decode_stage;

  localparam logic [11:0] F_PF = 12'h800, F_SRC2 = 12'h400, F_LINK = 12'h200;
  localparam logic [11:0] F_MR = 12'h100, F_MW = 12'h080, F_WFM = 12'h040;
  localparam logic [11:0] F_WP = 12'h020, F_WG = 12'h010, F_JMP = 12'h008;
  localparam logic [11:0] F_JIMM = 12'h004, F_RY = 12'h002, F_RX = 12'h001;

  logic clk = 0;
  logic rst = 1;
  logic [31:0] pc_next = 0, inst = 0, r_wr_data = 0;
  logic p_wr = 0, p_wr_data = 0, r_wr = 0;
  logic [1:0] p_wr_id = 0;
  logic [3:0] r_wr_id = 0;
  logic px, py, pval, pf_imm, src2_imm, link, mem_read, mem_write, wb_from_mem;
  logic wb_pred, wb_greg, is_jump, jump_imm, has_ry, has_rx;
  logic [31:0] rx, ry, imm, jmp_target;
  logic [3:0] z_id, x_id, y_id, alu_op;
  integer seed = 82436;
  int errors = 0;
  logic [31:0] gm [16];  // expected register contents
  logic pm [4];

  always #10 clk = ~clk;

  decode_stage u_decode_stage (.*);

  // {x from rz, alu_op, flags}
  function automatic logic [16:0] expected_ctrl(input logic [5:0] op);
    case (op)
      `OP_LD: return {1'b0, 4'd1, F_PF | F_SRC2 | F_MR | F_WFM | F_WG | F_RY};
      `OP_ST: return {1'b1, 4'd1, F_PF | F_SRC2 | F_MW | F_RY};
      `OP_ANDP, `OP_ORP, `OP_XORP, `OP_NOTP: return {1'b0, 4'(op - 6'h26), F_WP};
      `OP_RTOP: return {1'b0, 4'd5, F_WP | F_RY};
      `OP_ISNEG: return {1'b0, 4'd6, F_WP | F_RY};
      `OP_ISZERO: return {1'b0, 4'd7, F_WP | F_RY};
      `OP_LDI: return {1'b0, 4'd13, F_PF | F_SRC2 | F_WG};
      `OP_ANDI, `OP_ORI, `OP_XORI: return {1'b0, 4'(op - 6'd9), F_PF | F_SRC2 | F_WG | F_RY};
      `OP_ADDI, `OP_SUBI, `OP_MULI, `OP_DIVI, `OP_MODI, `OP_SHLI, `OP_SHRI:
        return {1'b0, 4'(op - 6'h13), F_PF | F_SRC2 | F_WG | F_RY};
      `OP_AND, `OP_OR, `OP_XOR: return {1'b0, 4'(op + 6'd1), F_PF | F_WG | F_RX | F_RY};
      `OP_ADD, `OP_SUB, `OP_MUL, `OP_DIV, `OP_MOD, `OP_SHL, `OP_SHR:
        return {1'b0, 4'(op - 6'd9), F_PF | F_WG | F_RX | F_RY};
      `OP_NEG: return {1'b0, 4'd11, F_PF | F_WG | F_RY};
      `OP_NOT: return {1'b0, 4'd12, F_PF | F_WG | F_RY};
      `OP_JMPI: return {1'b0, 4'd0, F_JIMM | F_JMP};
      `OP_JMPR: return {1'b1, 4'd0, F_RX | F_JMP};
      `OP_JALI: return {1'b0, 4'd14, F_PF | F_LINK | F_WG | F_JIMM | F_JMP};
      `OP_JALR: return {1'b0, 4'd14, F_PF | F_LINK | F_WG | F_RX | F_JMP};
      default: return 17'h0;  // nop, float, unknown
    endcase
  endfunction

  function automatic logic [31:0] expected_imm(input logic [5:0] op, input logic [22:0] fld);
    case (op)
      `OP_LD, `OP_ST, `OP_ANDI, `OP_ORI, `OP_XORI, `OP_ADDI, `OP_SUBI, `OP_MULI, `OP_DIVI,
      `OP_MODI, `OP_SHLI, `OP_SHRI: return {{17{fld[14]}}, fld[14:0]};
      `OP_JMPI: return {{9{fld[22]}}, fld[22:0]};
      `OP_LDI, `OP_JALI: return {{13{fld[18]}}, fld[18:0]};
      default: return 32'h0;
    endcase
  endfunction

  task automatic report_err(input string name, input logic [31:0] got, input logic [31:0] exp);
    errors++;
    $display("[ERROR] %s got %h expected %h at %0t", name, got, exp, $time);
  endtask

  task automatic drive(input logic [31:0] w, input logic [31:0] pc);
    @(posedge clk);
    #2;
    inst = w;
    pc_next = pc;
  endtask

  // sampled mid cycle, before the next edge
  task automatic check_outputs();
    logic [16:0] e;
    logic [3:0] ex;
    logic [31:0] ei;
    logic [15:0] got;
    #6;
    e = expected_ctrl(inst[28:23]);
    ex = e[16] ? inst[22:19] : inst[14:11];
    ei = expected_imm(inst[28:23], inst[22:0]);
    got = {alu_op, pf_imm, src2_imm, link, mem_read, mem_write, wb_from_mem, wb_pred,
           wb_greg, is_jump, jump_imm, has_ry, has_rx};
    assert (got == e[15:0]) else report_err("ctrl", 32'(got), 32'(e[15:0]));
    assert (x_id == ex) else report_err("x_id", 32'(x_id), 32'(ex));
    assert (y_id == inst[18:15]) else report_err("y_id", 32'(y_id), 32'(inst[18:15]));
    assert (z_id == inst[22:19]) else report_err("z_id", 32'(z_id), 32'(inst[22:19]));
    assert (imm == ei) else report_err("imm", imm, ei);
    assert (jmp_target == pc_next + ei) else report_err("jmp_target", jmp_target, pc_next + ei);
    assert (rx == gm[ex]) else report_err("rx", rx, gm[ex]);
    assert (ry == gm[inst[18:15]]) else report_err("ry", ry, gm[inst[18:15]]);
    assert (px == pm[ex[1:0]]) else report_err("px", 32'(px), 32'(pm[ex[1:0]]));
    assert (py == pm[inst[16:15]]) else report_err("py", 32'(py), 32'(pm[inst[16:15]]));
    assert (pval == (inst[31] ? pm[inst[30:29]] : 1'b1))
    else report_err("pval", 32'(pval), 32'(inst[31] ? pm[inst[30:29]] : 1'b1));
  endtask

  initial
  begin : watchdog
    #2000000;
    $display("timeout: simulation did not finish in time");
    $display("=== FAIL ===");
    $finish;
  end

  initial
  begin
    int cyc;
    logic [31:0] w;
    logic [31:0] pc;
    for (int i = 0; i < 16; i++) gm[i] = 32'(i);
    pm[0] = 1'b1;
    pm[1] = 1'b1;
    pm[2] = 1'b0;
    pm[3] = 1'b0;
    cyc = 0;
    while (cyc < 3)  // reset held three edges
    begin
      @(posedge clk);
      cyc++;
    end
    #2;
    rst = 0;
    for (int i = 0; i < 16; i++)  // reset contents via add
    begin
      drive({3'b000, `OP_ADD, 4'd0, 4'(15 - i), 4'(i), 11'd0}, 32'h0);
      check_outputs();
    end
    for (int op = 0; op < 64; op++)  // full opcode sweep
    begin
      w = $random(seed);
      drive({w[31:29], 6'(op), w[22:0]}, $random(seed));
      check_outputs();
    end
    for (int n = 0; n < 24; n++)  // writes show up one cycle later
    begin
      w = $random(seed);
      drive({3'b000, `OP_ADD, 4'd0, w[7:4], w[3:0], 11'd0}, 32'h0);
      r_wr = w[8];
      r_wr_id = w[3:0];
      r_wr_data = $random(seed);
      p_wr = w[9];
      p_wr_id = w[1:0];
      p_wr_data = w[10];
      check_outputs();
      if (r_wr) gm[r_wr_id] = r_wr_data;
      if (p_wr) pm[p_wr_id] = p_wr_data;
      drive(inst, 32'h0);
      r_wr = 0;
      p_wr = 0;
      check_outputs();
    end
    for (int n = 0; n < 300; n++)  // random instructions, guards included
    begin
      w = $random(seed);
      pc = $random(seed);
      drive(w, pc);
      check_outputs();
    end
    @(posedge clk);
    $display("errors: %0d testbench checks, %0d assertion checks",
             errors, u_decode_stage.u_decode_checker.fail_cnt);
    if (errors == 0 && u_decode_stage.u_decode_checker.fail_cnt == 0)
    begin
      $display("=== PASS ===");
    end
    else
    begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* decode_stage.f */
+incdir+source
source/decode_pkg.sv
source/instr_decoder.sv
source/pred_reg_file.sv
source/gen_reg_file.sv
source/imm_branch_unit.sv
source/decode_stage.sv
testbench/decode_checker.sv
testbench/tb_decode_stage.sv

/* Makefile */
TOP = tb_decode_stage

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f decode_stage.f --top-module $(TOP)

obj_dir/sim_$(TOP):
	verilator --binary --timing --assert -f decode_stage.f --top-module $(TOP) \
		-o sim_$(TOP)

sim: obj_dir/sim_$(TOP)
	./obj_dir/sim_$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log
